// ==== hdl/dram_sched_pkg.sv ====
package dram_sched_pkg;

  // ####################
  // sizes and address map
  // ####################

  // way sources feeding the scheduler
  localparam int NUM_WAYS = 8;

  // start distance between way read regions
  localparam logic [31:0] WAY_SPAN = 32'h0000_1000;
  // step after each read
  localparam logic [31:0] RD_STRIDE = 32'h40;
  // step after each write
  localparam logic [31:0] WR_STRIDE = 32'h80;
  // offset of the upper memory half
  localparam logic [31:0] HALF_BASE = 32'h0010_0000;

  // burst lengths per command
  localparam logic [7:0] RD_BLOCKS = 8'd4;
  localparam logic [7:0] WR_BLOCKS = 8'd8;

  // ####################
  // types
  // ####################

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_op_e;

  // one DRAM access, 41 bits
  typedef struct packed {
    cmd_op_e     op;
    logic [31:0] addr;
    logic [7:0]  blocks;
  } dram_cmd_t;

  // two request levels, one bit per way
  typedef struct packed {
    logic [NUM_WAYS-1:0] urgent;
    logic [NUM_WAYS-1:0] normal;
  } way_req_t;

  typedef enum logic [1:0] {
    PORT_IDLE    = 2'd0,
    PORT_REQ     = 2'd1,
    PORT_RELEASE = 2'd2
  } port_state_e;

endpackage

// ==== hdl/way_arbiter.sv ====
`timescale 1ns/1ps

module way_arbiter #(
  parameter int WAY_READS = 3
) (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                start,
  input  logic                                half,
  input  dram_sched_pkg::way_req_t            way_req,
  input  logic                                wr_req,
  input  logic                                full,
  output logic [dram_sched_pkg::NUM_WAYS-1:0] grant,
  output logic                                wr_grant,
  output logic                                push,
  output dram_sched_pkg::dram_cmd_t           push_cmd
);

  localparam int NW    = dram_sched_pkg::NUM_WAYS;
  localparam int CNT_W = $clog2(WAY_READS + 1);

  // isolate the lowest set bit, lowest way wins
  function automatic logic [NW-1:0] first_set(input logic [NW-1:0] vec);
    return vec & (~vec + 1'b1);
  endfunction

  // sampled requests
  dram_sched_pkg::way_req_t req_q;
  logic                     wr_q;

  // per run state
  logic                     half_q;
  logic [31:0]              rd_addr [NW];
  logic [CNT_W-1:0]         rd_cnt [NW];
  logic [31:0]              wr_addr;

  // choice
  logic [NW-1:0]            has_budget;
  logic [NW-1:0]            urg_ok;
  logic [NW-1:0]            nrm_ok;
  logic [NW-1:0]            rd_sel;
  logic [31:0]              sel_addr;
  logic                     can_grant;

  // run init, start reloads counters like reset
  logic                     run_init;
  logic                     init_half;

  // ####################
  // request sampling
  // ####################

  always_ff @(posedge CLK) begin
    if (RST) begin
      req_q <= '0;
      wr_q  <= 1'b0;
    end else begin
      req_q <= way_req;
      wr_q  <= wr_req;
    end
  end

  // ####################
  // priority pick
  // ####################

  always_comb begin
    for (int i = 0; i < NW; i++) begin
      has_budget[i] = rd_cnt[i] != CNT_W'(WAY_READS);
    end
  end

  // spent ways drop out of both levels
  assign urg_ok = req_q.urgent & has_budget;
  assign nrm_ok = req_q.normal & has_budget;

  // urgent first, then normal
  assign rd_sel = (|urg_ok) ? first_set(urg_ok) : first_set(nrm_ok);

  // hold off while buffer full or a run restarts
  assign can_grant = !full && !start;

  assign grant    = can_grant ? rd_sel : '0;
  // write only when no read is eligible
  assign wr_grant = can_grant && !(|rd_sel) && wr_q;
  assign push     = (|grant) || wr_grant;

  // address of the selected way
  always_comb begin
    sel_addr = '0;
    for (int i = 0; i < NW; i++) begin
      if (rd_sel[i]) begin
        sel_addr = rd_addr[i];
      end
    end
  end

  // command build
  always_comb begin
    if (|rd_sel) begin
      push_cmd.op     = dram_sched_pkg::CMD_READ;
      // reads go to the half selected at start
      push_cmd.addr   = sel_addr + (half_q ? dram_sched_pkg::HALF_BASE : 32'h0);
      push_cmd.blocks = dram_sched_pkg::RD_BLOCKS;
    end else begin
      push_cmd.op     = dram_sched_pkg::CMD_WRITE;
      push_cmd.addr   = wr_addr;
      push_cmd.blocks = dram_sched_pkg::WR_BLOCKS;
    end
  end

  // ####################
  // address counters
  // ####################

  assign run_init  = RST || start;
  // half is cleared by reset, latched by start
  assign init_half = !RST && half;

  always_ff @(posedge CLK) begin
    if (run_init) begin
      half_q  <= init_half;
      // writes land opposite to reads
      wr_addr <= init_half ? 32'h0 : dram_sched_pkg::HALF_BASE;
      for (int i = 0; i < NW; i++) begin
        rd_addr[i] <= 32'(i) * dram_sched_pkg::WAY_SPAN;
        rd_cnt[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NW; i++) begin
        if (grant[i]) begin
          rd_addr[i] <= rd_addr[i] + dram_sched_pkg::RD_STRIDE;
          rd_cnt[i]  <= rd_cnt[i] + 1'b1;
        end
      end
      if (wr_grant) begin
        wr_addr <= wr_addr + dram_sched_pkg::WR_STRIDE;
      end
    end
  end

endmodule

// ==== hdl/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      push,
  input  dram_sched_pkg::dram_cmd_t push_cmd,
  input  logic                      pop,
  output dram_sched_pkg::dram_cmd_t head,
  output logic                      empty,
  output logic                      full
);

  // pointer width, depth is a power of two
  localparam int AW = $clog2(DEPTH);

  dram_sched_pkg::dram_cmd_t mem [DEPTH];
  logic [AW-1:0]             wr_ptr;
  logic [AW-1:0]             rd_ptr;
  logic [AW:0]               count;

  // ####################
  // storage
  // ####################

  // producer checks full before pushing
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // ####################
  // pointers and occupancy
  // ####################

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry always on head
  assign head  = mem[rd_ptr];
  assign empty = count == '0;
  assign full  = count == (AW + 1)'(DEPTH);

endmodule

// ==== hdl/dram_port.sv ====
`timescale 1ns/1ps

module dram_port (
  input  logic                      CLK,
  input  logic                      RST,
  input  dram_sched_pkg::dram_cmd_t head,
  input  logic                      empty,
  input  logic                      cmd_ack,
  output logic                      pop,
  output dram_sched_pkg::dram_cmd_t cmd,
  output logic                      cmd_req
);

  dram_sched_pkg::port_state_e state;

  // ####################
  // handshake FSM
  // ####################

  // retire head on first sampled ack
  assign pop = (state == dram_sched_pkg::PORT_REQ) && cmd_ack;

  always_ff @(posedge CLK) begin
    if (RST) begin
      state   <= dram_sched_pkg::PORT_IDLE;
      cmd_req <= 1'b0;
    end else begin
      case (state)
        dram_sched_pkg::PORT_IDLE: begin
          // new command waiting
          if (!empty) begin
            cmd_req <= 1'b1;
            state   <= dram_sched_pkg::PORT_REQ;
          end
        end
        dram_sched_pkg::PORT_REQ: begin
          // DRAM took it, drop req
          if (cmd_ack) begin
            cmd_req <= 1'b0;
            state   <= dram_sched_pkg::PORT_RELEASE;
          end
        end
        dram_sched_pkg::PORT_RELEASE: begin
          // ack must fall before the next req
          if (!cmd_ack) begin
            state <= dram_sched_pkg::PORT_IDLE;
          end
        end
        default: begin
          cmd_req <= 1'b0;
          state   <= dram_sched_pkg::PORT_IDLE;
        end
      endcase
    end
  end

  // ####################
  // command register
  // ####################

  // loaded with req rise, held until the next idle pickup
  always_ff @(posedge CLK) begin
    if (state == dram_sched_pkg::PORT_IDLE && !empty) begin
      cmd <= head;
    end
  end

endmodule

// ==== hdl/dram_sched.sv ====
`timescale 1ns/1ps

module dram_sched #(
  parameter int WAY_READS  = 3,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                start,
  input  logic                                half,
  input  dram_sched_pkg::way_req_t            way_req,
  input  logic                                wr_req,
  output logic [dram_sched_pkg::NUM_WAYS-1:0] grant,
  output logic                                wr_grant,
  output dram_sched_pkg::dram_cmd_t           cmd,
  output logic                                cmd_req,
  input  logic                                cmd_ack
);

  // arbiter to buffer
  logic                      push;
  dram_sched_pkg::dram_cmd_t push_cmd;
  logic                      full;

  // buffer to port
  dram_sched_pkg::dram_cmd_t head;
  logic                      empty;
  logic                      pop;

  // ####################
  // producer
  // ####################

  way_arbiter #(
    .WAY_READS (WAY_READS)
  ) u_arbiter (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .half     (half),
    .way_req  (way_req),
    .wr_req   (wr_req),
    .full     (full),
    .grant    (grant),
    .wr_grant (wr_grant),
    .push     (push),
    .push_cmd (push_cmd)
  );

  // command buffer, grant order kept
  cmd_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLK      (CLK),
    .RST      (RST),
    .push     (push),
    .push_cmd (push_cmd),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (full)
  );

  // ####################
  // consumer
  // ####################

  dram_port u_port (
    .CLK     (CLK),
    .RST     (RST),
    .head    (head),
    .empty   (empty),
    .cmd_ack (cmd_ack),
    .pop     (pop),
    .cmd     (cmd),
    .cmd_req (cmd_req)
  );

endmodule

// ==== test/dram_sched_chk.sv ====
`timescale 1ns/1ps

module dram_sched_chk (
  input logic                                CLK,
  input logic                                RST,
  input logic [dram_sched_pkg::NUM_WAYS-1:0] grant,
  input logic                                wr_grant,
  input dram_sched_pkg::dram_cmd_t           cmd,
  input logic                                cmd_req,
  input logic                                cmd_ack
);

  // failed assertions so far
  int fail_count = 0;

  // ####################
  // DRAM handshake
  // ####################

  // command frozen for the whole request phase
  cmd_hold: assert property (@(posedge CLK) disable iff (RST)
    cmd_req && $past(cmd_req) |-> $stable(cmd))
    else begin
      $error("cmd changed while cmd_req was high");
      fail_count++;
    end

  // new request only after ack has fallen
  req_after_ack: assert property (@(posedge CLK) disable iff (RST)
    $rose(cmd_req) |-> !$past(cmd_ack))
    else begin
      $error("cmd_req rose while cmd_ack was high");
      fail_count++;
    end

  // ####################
  // grants
  // ####################

  // one grant per cycle at most
  one_grant: assert property (@(posedge CLK) disable iff (RST)
    $onehot0(grant) && !(wr_grant && (|grant)))
    else begin
      $error("more than one grant in a cycle");
      fail_count++;
    end

endmodule

bind dram_sched dram_sched_chk u_chk (
  .CLK      (CLK),
  .RST      (RST),
  .grant    (grant),
  .wr_grant (wr_grant),
  .cmd      (cmd),
  .cmd_req  (cmd_req),
  .cmd_ack  (cmd_ack)
);

// ==== test/tb_dram_sched.sv ====
`timescale 1ns/1ps

module tb_dram_sched;

  localparam int NW        = dram_sched_pkg::NUM_WAYS;
  localparam int WAY_READS = 3;
  localparam int NUM_ROWS  = 5;

  // one scheduler run
  typedef struct packed {
    logic          half;
    logic [NW-1:0] urgent;
    logic [NW-1:0] normal;
    int            reps;
    int            writes;
  } row_t;

  // ####################
  // stimulus table
  // ####################

  // half, urgent mask, normal mask, reads per way, writes
  row_t rows [NUM_ROWS] = '{
    '{1'b0, 8'h24, 8'h81, 1, 2},
    '{1'b1, 8'h81, 8'h10, 2, 3},
    // way 1 asks for more than its budget
    '{1'b0, 8'h00, 8'h02, 5, 2},
    // budget back after a new start
    '{1'b0, 8'h00, 8'h02, 1, 0},
    '{1'b1, 8'hf0, 8'h0f, 3, 4}   // all ways, FIFO fills up
  };

  logic                      CLK;
  logic                      RST;
  logic                      start;
  logic                      half;
  dram_sched_pkg::way_req_t  way_req;
  logic                      wr_req;
  logic [NW-1:0]             grant;
  logic                      wr_grant;
  dram_sched_pkg::dram_cmd_t cmd;
  logic                      cmd_req;
  logic                      cmd_ack;

  // reference model
  dram_sched_pkg::dram_cmd_t exp_q [$];
  logic [31:0]               m_addr [NW];
  int                        m_cnt [NW];
  logic [31:0]               m_wr;
  logic                      m_half;

  // way sources and write source
  row_t cur;
  int   reps_left [NW];
  int   wr_left;
  int   row_done;
  int   row_expect;

  int          cycles;
  int          limit;
  logic [31:0] rng;

  dram_sched #(
    .WAY_READS  (WAY_READS),
    .FIFO_DEPTH (4)
  ) i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .half     (half),
    .way_req  (way_req),
    .wr_req   (wr_req),
    .grant    (grant),
    .wr_grant (wr_grant),
    .cmd      (cmd),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack)
  );

  always #5 CLK = ~CLK;

  // ####################
  // helpers
  // ####################

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_grant(input logic [NW-1:0] got, input logic [NW-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("FAIL %0t grant got %b exp %b", $time, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("FAIL %0t %s got %b exp %b", $time, name, got, exp));
  endtask

  task automatic check_cmd(input dram_sched_pkg::dram_cmd_t got,
                           input dram_sched_pkg::dram_cmd_t exp);
    if (got !== exp)
      report_failure($sformatf(
        "FAIL %0t cmd got op=%0d addr=%h blocks=%0d exp op=%0d addr=%h blocks=%0d",
        $time, got.op, got.addr, got.blocks, exp.op, exp.addr, exp.blocks));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // commands one row produces, budget capped
  function automatic int row_cmds(input row_t r);
    int n;
    n = r.writes;
    for (int i = 0; i < NW; i++) begin
      if (r.urgent[i] || r.normal[i])
        n += (r.reps < WAY_READS) ? r.reps : WAY_READS;
    end
    return n;
  endfunction

  // counters as a start pulse leaves them
  task automatic model_reset(input logic h);
    m_half = h;
    m_wr   = h ? 32'h0 : dram_sched_pkg::HALF_BASE;
    for (int i = 0; i < NW; i++) begin
      m_addr[i] = i * dram_sched_pkg::WAY_SPAN;
      m_cnt[i]  = 0;
    end
  endtask

  // a granted way drops for one cycle
  task automatic drive_sources(input logic [NW-1:0] granted);
    logic [NW-1:0] active;
    for (int i = 0; i < NW; i++)
      active[i] = reps_left[i] > 0 && !granted[i] && row_done < row_expect;
    way_req.urgent = active & cur.urgent;
    way_req.normal = active & cur.normal;
    wr_req         = wr_left > 0 && row_done < row_expect;
  endtask

  // one falling edge, requests now driven are the sampled ones
  task automatic step();
    int                        pick;
    logic [NW-1:0]             exp_grant;
    logic                      exp_wr;
    dram_sched_pkg::dram_cmd_t c;
    pick = -1;
    // downward scan, lowest way ends up picked
    for (int i = NW - 1; i >= 0; i--) begin
      if (way_req.normal[i] && m_cnt[i] < WAY_READS)
        pick = i;
    end
    for (int i = NW - 1; i >= 0; i--) begin
      if (way_req.urgent[i] && m_cnt[i] < WAY_READS)
        pick = i;
    end
    exp_grant = '0;
    if (pick >= 0)
      exp_grant[pick] = 1'b1;
    exp_wr = (pick < 0) && wr_req;
    // a full buffer holds every grant back
    if (i_dut.full) begin
      exp_grant = '0;
      exp_wr    = 1'b0;
    end
    check_grant(grant, exp_grant);
    check_flag("wr_grant", wr_grant, exp_wr);
    if ((|exp_grant) || exp_wr) begin
      if (pick >= 0) begin
        c.op   = dram_sched_pkg::CMD_READ;
        c.addr = m_addr[pick] + (m_half ? dram_sched_pkg::HALF_BASE : 32'h0);
        c.blocks = dram_sched_pkg::RD_BLOCKS;
        m_addr[pick] += dram_sched_pkg::RD_STRIDE;
        m_cnt[pick]++;
        reps_left[pick]--;
      end else begin
        c.op     = dram_sched_pkg::CMD_WRITE;
        c.addr   = m_wr;
        c.blocks = dram_sched_pkg::WR_BLOCKS;
        m_wr += dram_sched_pkg::WR_STRIDE;
        wr_left--;
      end
      exp_q.push_back(c);
      row_done++;
    end
    drive_sources(grant);
  endtask

  // ####################
  // DRAM responder
  // ####################

  initial begin : dram_responder
    int delay;
    forever begin
      @(negedge CLK);
      if (cmd_req && !cmd_ack) begin
        if (exp_q.size() == 0)
          report_failure("DRAM command issued while none was expected");
        else
          check_cmd(cmd, exp_q.pop_front());
        rng   = xorshift(rng);
        delay = rng % 7;
        repeat (delay) @(negedge CLK);
        cmd_ack = 1'b1;
        // hold ack until req falls
        do @(negedge CLK); while (cmd_req);
        cmd_ack = 1'b0;
      end
    end
  end

  // watchdog and assertion monitor
  always @(posedge CLK) begin
    cycles++;
    if (cycles > limit)
      report_failure($sformatf("timeout, no progress after %0d cycles", cycles));
    if (i_dut.u_chk.fail_count != 0)
      report_failure("a DRAM port assertion failed");
  end

  // ####################
  // main sequence
  // ####################

  initial begin
    CLK     = 1'b0;
    RST     = 1'b1;
    start   = 1'b0;
    half    = 1'b0;
    way_req = '0;
    wr_req  = 1'b0;
    cmd_ack = 1'b0;
    rng     = 32'h6a831627;
    cycles  = 0;
    limit   = 100;
    for (int r = 0; r < NUM_ROWS; r++)
      limit += 40 * row_cmds(rows[r]);
    cur        = '0;
    wr_left    = 0;
    row_done   = 0;
    row_expect = 0;
    for (int i = 0; i < NW; i++)
      reps_left[i] = 0;
    repeat (2) @(negedge CLK);
    // outputs quiet out of reset
    check_grant(grant, '0);
    check_flag("wr_grant", wr_grant, 1'b0);
    check_flag("cmd_req", cmd_req, 1'b0);
    RST = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur = rows[r];
      // start pulse, sources quiet
      @(negedge CLK);
      step();
      start = 1'b1;
      half  = cur.half;
      model_reset(cur.half);
      @(negedge CLK);
      step();
      start = 1'b0;
      for (int i = 0; i < NW; i++)
        reps_left[i] = (cur.urgent[i] || cur.normal[i]) ? cur.reps : 0;
      wr_left    = cur.writes;
      row_done   = 0;
      row_expect = row_cmds(cur);
      drive_sources('0);
      while (row_done < row_expect) begin
        @(negedge CLK);
        step();
      end
    end

    // drain buffer and last handshake
    while (exp_q.size() != 0)
      @(negedge CLK);
    while (cmd_req || cmd_ack)
      @(negedge CLK);
    repeat (5) @(negedge CLK);
    if (cmd_req || i_dut.u_chk.fail_count != 0)
      report_failure("extra DRAM command or assertion failure at end of run");
    else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== dram_sched.f ====
hdl/dram_sched_pkg.sv
hdl/way_arbiter.sv
hdl/cmd_fifo.sv
hdl/dram_port.sv
hdl/dram_sched.sv
test/dram_sched_chk.sv
test/tb_dram_sched.sv
